//--- bench/colorMazePatterns.txt
// rep rectBtns playerBtns playerH playerV color  newH newV mask rectH rectV, all hex
// mask bits are up down left right, rect checked on the last step of a repeat run
001 4 0 00a 00a 1  00a 00a 0 12c 0c9
001 8 0 00a 00a 1  00a 00a 0 12c 0c8
001 2 0 00a 00a 1  00a 00a 0 12d 0c8
001 1 0 00a 00a 1  00a 00a 0 12c 0c8
001 0 0 00a 00a 1  00a 00a 0 12c 0c8
001 3 0 00a 00a 1  00a 00a 0 12c 0c8
// full wrap up, then down wraps from the bottom and climbs back
0c9 8 0 00a 00a 1  00a 00a 0 12c 1b8
001 4 0 00a 00a 1  00a 00a 0 12c 000
0c8 4 0 00a 00a 1  00a 00a 0 12c 0c8
// full wrap left, then right wraps from the edge and returns
12d 1 0 00a 00a 1  00a 00a 0 230 0c8
001 2 0 00a 00a 1  00a 00a 0 000 0c8
12c 2 0 00a 00a 1  00a 00a 0 12c 0c8
// different color against top, bottom, left, right border
001 0 4 140 0bc 1  140 0bc 4 12c 0c8
001 0 2 140 0bc 1  141 0bc 4 12c 0c8
001 0 8 140 0f0 1  140 0f0 8 12c 0c8
001 0 2 120 0d2 1  120 0d2 1 12c 0c8
001 0 1 17c 0d2 1  17c 0d2 2 12c 0c8
001 0 8 17c 0d2 1  17c 0d1 2 12c 0c8
// same color passes
001 0 4 140 0bc 3  140 0bd 0 12c 0c8
001 0 8 140 0f0 3  140 0ef 0 12c 0c8
001 0 2 120 0d2 3  121 0d2 0 12c 0c8
001 0 1 17c 0d2 3  17b 0d2 0 12c 0c8
// overhang and flush span edges
001 0 4 127 0bc 1  127 0bd 0 12c 0c8
001 0 4 170 0bc 1  170 0bc 4 12c 0c8
001 0 4 172 0bc 1  172 0bd 0 12c 0c8
// screen clamp at both corners
001 0 8 000 000 1  000 000 0 12c 0c8
001 0 1 000 000 1  000 000 0 12c 0c8
001 0 2 274 1d4 1  274 1d4 0 12c 0c8
001 0 4 274 1d4 1  274 1d4 0 12c 0c8
// block against the rectangle after this step's move
001 4 4 140 0bd 1  140 0bd 4 12c 0c9

//--- colorMaze.f
+incdir+bench
hdl/gamePkg.sv
hdl/pipeReg.sv
hdl/rectStage.sv
hdl/collideStage.sv
hdl/playerStage.sv
hdl/colorMaze.sv
bench/colorMazeTb.sv

//--- runSim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module colorMazeTb \
    -f colorMaze.f -o colorMazeSim || exit 1
simOut=$(./obj_dir/colorMazeSim)
echo "$simOut"
echo "$simOut" | grep -qx '>>> PASS' && exit 0 || exit 1

//--- bench/colorMazeChecks.svh
`ifndef COLOR_MAZE_CHECKS_SVH
`define COLOR_MAZE_CHECKS_SVH

// compares for the fields of stepResT, idx is the result number

task automatic checkPos(input int idx, input coordT gotH, input coordT gotV,
                        input coordT expH, input coordT expV);
    if (gotH !== expH || gotV !== expV)
        failNow($sformatf("[FAIL] %0t ns: result %0d player at (%0d,%0d), expected (%0d,%0d)",
                          $time, idx, gotH, gotV, expH, expV));
endtask

// mask printed as up down left right
task automatic checkBlock(input int idx, input blockT got, input blockT exp);
    if (got !== exp)
        failNow($sformatf("[FAIL] %0t ns: result %0d block mask %b, expected %b",
                          $time, idx, got, exp));
endtask

task automatic checkRect(input int idx, input coordT gotH, input coordT gotV,
                         input coordT expH, input coordT expV);
    if (gotH !== expH || gotV !== expV)
        failNow($sformatf("[FAIL] %0t ns: result %0d rectangle at (%0d,%0d), expected (%0d,%0d)",
                          $time, idx, gotH, gotV, expH, expV));
endtask

`endif

//--- bench/colorMazeTb.sv
`timescale 1ns/1ps
`default_nettype none

module colorMazeTb;

    import gamePkg::*;

    localparam logic [31:0] Seed = 32'hba66_46c5;

    // rectangle at (300,200), 80 by 40, color 3
    localparam rectCfgT Cfg = '{hStart: 10'd300, vStart: 10'd200, width: 10'd80,
                                height: 10'd40, color: 4'd3};

    typedef struct packed {
        stepResT res;
        logic    lastOfRun;  // rectangle only known at the end of a run
    } expT;

    logic    btnClk     = 1'b0;
    logic    rst        = 1'b1;
    logic    inValid_i  = 1'b0;
    stepReqT req_i      = '0;
    logic    outReady_i = 1'b0;
    logic    inReady_o;
    logic    outValid_o;
    stepResT res_o;

    stepReqT reqQ[$];            // requests in file order
    expT     expQ[$];            // results still owed by the DUT
    expT     expItem;
    int      driveSeed  = int'(Seed);
    int      readySeed  = int'(Seed);
    int      totalReqs  = 0;
    int      doneCount  = 0;     // results checked so far
    int      cycleCount = 0;
    int      cycleLimit = 100;

    colorMaze dut (
        .btnClk     (btnClk),
        .rst        (rst),
        .cfg_i      (Cfg),
        .inValid_i  (inValid_i),
        .inReady_o  (inReady_o),
        .req_i      (req_i),
        .outValid_o (outValid_o),
        .outReady_i (outReady_i),
        .res_o      (res_o)
    );

    always #5 btnClk = ~btnClk;  // 100 MHz

    task automatic failNow(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    `include "colorMazeChecks.svh"

    ////////////////////////////////////////////////////////////
    // pattern file with repeat counts expanded into single steps
    ////////////////////////////////////////////////////////////

    task automatic loadPatterns;
        int      fd;
        int      n;
        int      rep, rb, pb, pH, pV, pC;
        int      eH, eV, eM, eRH, eRV;
        string   line;
        stepReqT req;
        expT     want;
        fd = $fopen("bench/colorMazePatterns.txt", "r");
        if (fd == 0)
            failNow("error: cannot open bench/colorMazePatterns.txt");
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "/")
                continue;  // blank or note
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                        rep, rb, pb, pH, pV, pC, eH, eV, eM, eRH, eRV);
            if (n != 11)
                failNow($sformatf("error: malformed pattern line %s", line));
            req = '{rectBtns: btnT'(rb), playerBtns: btnT'(pb), playerH: coordT'(pH),
                    playerV: coordT'(pV), playerColor: colorT'(pC)};
            want.res = '{newH: coordT'(eH), newV: coordT'(eV), block: blockT'(4'(eM)),
                         rectH: coordT'(eRH), rectV: coordT'(eRV)};
            for (int k = 0; k < rep; k++)
            begin
                want.lastOfRun = (k == rep - 1);
                reqQ.push_back(req);
                expQ.push_back(want);
            end
        end
        $fclose(fd);
        totalReqs  = reqQ.size();
        cycleLimit = 20 * totalReqs + 100;  // generous per step, stalls included
    endtask

    task automatic sendRequests;
        logic taken;
        for (int idx = 0; idx < totalReqs; idx++)
        begin
            if (($random(driveSeed) & 3) == 0)
            begin
                inValid_i <= 1'b0;  // one idle cycle
                @(posedge btnClk);
            end
            inValid_i <= 1'b1;
            req_i     <= reqQ[idx];
            taken = 1'b0;
            while (!taken)
            begin
                @(negedge btnClk);
                taken = inReady_o;  // settled mid cycle
                @(posedge btnClk);
            end
        end
        inValid_i <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // sink side with random stalls and in-order checking
    ////////////////////////////////////////////////////////////

    always @(posedge btnClk)
    begin
        if (!rst)
            outReady_i <= ($random(readySeed) & 3) != 0;  // stall about one in four
    end

    // transfer happens at the next rising edge
    always @(negedge btnClk)
    begin
        if (!rst && outValid_o && outReady_i)
        begin
            if (expQ.size() == 0)
                failNow("error: DUT produced a result with no request outstanding");
            expItem = expQ.pop_front();
            checkPos(doneCount, res_o.newH, res_o.newV, expItem.res.newH, expItem.res.newV);
            checkBlock(doneCount, res_o.block, expItem.res.block);
            if (expItem.lastOfRun)
                checkRect(doneCount, res_o.rectH, res_o.rectV,
                          expItem.res.rectH, expItem.res.rectV);
            doneCount++;
        end
    end

    always @(posedge btnClk)
    begin
        cycleCount++;
        if (cycleCount > cycleLimit)
            failNow($sformatf("error: run timed out after %0d cycles", cycleCount));
    end

    initial
    begin
        loadPatterns();
        repeat (4) @(posedge btnClk);
        rst <= 1'b0;
        @(negedge btnClk);
        if (outValid_o !== 1'b0 || inReady_o !== 1'b1)
            failNow("error: handshake outputs not idle after reset");
        @(posedge btnClk);
        sendRequests();
        wait (doneCount == totalReqs);
        repeat (5) @(posedge btnClk);  // a stray extra result would fail here
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/colorMaze.sv
`timescale 1ns/1ps
`default_nettype none

// movement and collision core, three stage pipe
module colorMaze (
    input  wire logic             btnClk,
    input  wire logic             rst,
    input  wire gamePkg::rectCfgT cfg_i,
    input  wire logic             inValid_i,
    output logic                  inReady_o,
    input  wire gamePkg::stepReqT req_i,
    output logic                  outValid_o,
    input  wire logic             outReady_i,
    output gamePkg::stepResT      res_o
);

    import gamePkg::*;

    logic        rectValid;     // stage 1 to stage 2
    logic        rectReady;
    rectStepT    rectStep;
    logic        collideValid;  // stage 2 to stage 3
    logic        collideReady;
    collideStepT collideStep;

    rectStage rectStg (
        .btnClk     (btnClk),
        .rst        (rst),
        .cfg_i      (cfg_i),
        .inValid_i  (inValid_i),
        .inReady_o  (inReady_o),
        .req_i      (req_i),
        .outValid_o (rectValid),
        .outReady_i (rectReady),
        .step_o     (rectStep)
    );

    collideStage collideStg (
        .btnClk     (btnClk),
        .rst        (rst),
        .cfg_i      (cfg_i),
        .inValid_i  (rectValid),
        .inReady_o  (rectReady),
        .step_i     (rectStep),
        .outValid_o (collideValid),
        .outReady_i (collideReady),
        .step_o     (collideStep)
    );

    playerStage playerStg (
        .btnClk     (btnClk),
        .rst        (rst),
        .inValid_i  (collideValid),
        .inReady_o  (collideReady),
        .step_i     (collideStep),
        .outValid_o (outValid_o),
        .outReady_i (outReady_i),
        .res_o      (res_o)
    );

endmodule

`default_nettype wire

//--- hdl/playerStage.sv
`timescale 1ns/1ps
`default_nettype none

// stage 3, one pixel of player motion
module playerStage (
    input  wire logic                 btnClk,
    input  wire logic                 rst,
    input  wire logic                 inValid_i,
    output logic                      inReady_o,
    input  wire gamePkg::collideStepT step_i,
    output logic                      outValid_o,
    input  wire logic                 outReady_i,
    output gamePkg::stepResT          res_o
);

    import gamePkg::*;

    coordT   curH;   // player position as requested
    coordT   curV;
    blockT   mask;
    coordT   newH;
    coordT   newV;
    stepResT resIn;
    logic    accept;

    assign curH   = step_i.step.req.playerH;
    assign curV   = step_i.step.req.playerV;
    assign mask   = step_i.block;
    assign accept = inValid_i && inReady_o;

    always_comb
    begin
        newH = curH;
        newV = curV;
        case (step_i.step.req.playerBtns)
            BtnUp:
                if (!mask.up && curV > 0) newV = curV - 1'b1;
            BtnDown:
                if (!mask.down && curV < ScreenH - PlayerSize) newV = curV + 1'b1;
            BtnRight:
                if (!mask.right && curH < ScreenW - PlayerSize) newH = curH + 1'b1;
            BtnLeft:
                if (!mask.left && curH > 0) newH = curH - 1'b1;
            default: ;  // stay put
        endcase
    end

    assign resIn = '{newH: newH, newV: newV, block: mask,
                     rectH: step_i.step.rectH, rectV: step_i.step.rectV};

    pipeReg #(.PayloadT(stepResT)) outReg (
        .btnClk     (btnClk),
        .rst        (rst),
        .inValid_i  (inValid_i),
        .inReady_o  (inReady_o),
        .in_i       (resIn),
        .outValid_o (outValid_o),
        .outReady_i (outReady_i),
        .out_o      (res_o)
    );

    // result never steps into a blocked side
    assert property (@(posedge btnClk) disable iff (rst)
        accept |=>
            (!$past(mask.up)    || res_o.newV >= $past(curV)) &&
            (!$past(mask.down)  || res_o.newV <= $past(curV)) &&
            (!$past(mask.left)  || res_o.newH >= $past(curH)) &&
            (!$past(mask.right) || res_o.newH <= $past(curH)));

endmodule

`default_nettype wire

//--- hdl/collideStage.sv
`timescale 1ns/1ps
`default_nettype none

// stage 2 finds the player moves that the rectangle border refuses
module collideStage (
    input  wire logic              btnClk,
    input  wire logic              rst,
    input  wire gamePkg::rectCfgT  cfg_i,
    input  wire logic              inValid_i,
    output logic                   inReady_o,
    input  wire gamePkg::rectStepT step_i,
    output logic                   outValid_o,
    input  wire logic              outReady_i,
    output gamePkg::collideStepT   step_o
);

    import gamePkg::*;

    // edges one bit wider so the sums never wrap
    logic [10:0] pTop;
    logic [10:0] pBot;
    logic [10:0] pLeft;
    logic [10:0] pRight;
    logic [10:0] rTop;
    logic [10:0] rBot;
    logic [10:0] rLeft;
    logic [10:0] rRight;

    logic        hWithin;     // player columns inside rectangle columns
    logic        vWithin;     // player rows inside rectangle rows
    logic        colorMatch;  // same color lets the player through
    blockT       block;
    collideStepT stepIn;

    ////////////////////////////////////////////////////////////
    // edges of both boxes
    ////////////////////////////////////////////////////////////

    assign pLeft  = {1'b0, step_i.req.playerH};
    assign pRight = pLeft + 11'(PlayerSize);
    assign pTop   = {1'b0, step_i.req.playerV};
    assign pBot   = pTop + 11'(PlayerSize);

    assign rLeft  = {1'b0, step_i.rectH};
    assign rRight = rLeft + {1'b0, cfg_i.width};
    assign rTop   = {1'b0, step_i.rectV};
    assign rBot   = rTop + {1'b0, cfg_i.height};

    // inclusive on both sides so overhang is not blocked
    assign hWithin = (pLeft >= rLeft) && (pRight <= rRight);
    assign vWithin = (pTop >= rTop) && (pBot <= rBot);

    assign colorMatch = (step_i.req.playerColor == cfg_i.color);

    always_comb
    begin
        block = '0;
        if (!colorMatch)
        begin
            block.down  = (pBot == rTop) && hWithin;    // standing on top border
            block.up    = (pTop == rBot) && hWithin;    // under bottom border
            block.right = (pRight == rLeft) && vWithin; // against left border
            block.left  = (pLeft == rRight) && vWithin; // against right border
        end
    end

    assign stepIn = '{step: step_i, block: block};

    pipeReg #(.PayloadT(collideStepT)) outReg (
        .btnClk     (btnClk),
        .rst        (rst),
        .inValid_i  (inValid_i),
        .inReady_o  (inReady_o),
        .in_i       (stepIn),
        .outValid_o (outValid_o),
        .outReady_i (outReady_i),
        .out_o      (step_o)
    );

endmodule

`default_nettype wire

//--- hdl/rectStage.sv
`timescale 1ns/1ps
`default_nettype none

// stage 1, rectangle motion with wraparound
module rectStage (
    input  wire logic             btnClk,
    input  wire logic             rst,
    input  wire gamePkg::rectCfgT cfg_i,
    input  wire logic             inValid_i,
    output logic                  inReady_o,
    input  wire gamePkg::stepReqT req_i,
    output logic                  outValid_o,
    input  wire logic             outReady_i,
    output gamePkg::rectStepT     step_o
);

    import gamePkg::*;

    coordT    rectH;    // current left edge
    coordT    rectV;    // current top edge
    coordT    nextH;
    coordT    nextV;
    rectStepT stepIn;
    logic     accept;

    assign accept = inValid_i && inReady_o;

    ////////////////////////////////////////////////////////////
    // next position from the rectangle buttons
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        nextH = rectH;  // no move by default
        nextV = rectV;
        case (req_i.rectBtns)
            BtnUp:
            begin
                if (rectV > 0)
                    nextV = rectV - 1'b1;
                else
                    nextV = coordT'(ScreenH - cfg_i.height);  // bottom edge to screen bottom
            end
            BtnDown:
            begin
                if (rectV + cfg_i.height < ScreenH)
                    nextV = rectV + 1'b1;
                else
                    nextV = '0;  // back to the top
            end
            BtnRight:
            begin
                if (rectH + cfg_i.width < ScreenW)
                    nextH = rectH + 1'b1;
                else
                    nextH = '0;  // back to the left side
            end
            BtnLeft:
            begin
                if (rectH > 0)
                    nextH = rectH - 1'b1;
                else
                    nextH = coordT'(ScreenW - cfg_i.width);  // right edge to screen edge
            end
            default: ;  // zero or several buttons
        endcase
    end

    // position only advances on a taken request
    always_ff @(posedge btnClk or posedge rst)
    begin
        if (rst)
        begin
            rectH <= cfg_i.hStart;
            rectV <= cfg_i.vStart;
        end
        else if (accept)
        begin
            rectH <= nextH;
            rectV <= nextV;
        end
    end

    assign stepIn = '{req: req_i, rectH: nextH, rectV: nextV};

    pipeReg #(.PayloadT(rectStepT)) outReg (
        .btnClk     (btnClk),
        .rst        (rst),
        .inValid_i  (inValid_i),
        .inReady_o  (inReady_o),
        .in_i       (stepIn),
        .outValid_o (outValid_o),
        .outReady_i (outReady_i),
        .out_o      (step_o)
    );

    // whole rectangle inside the playfield
    assert property (@(posedge btnClk) disable iff (rst)
        (rectH + cfg_i.width <= ScreenW) && (rectV + cfg_i.height <= ScreenH));

endmodule

`default_nettype wire

//--- hdl/pipeReg.sv
`timescale 1ns/1ps
`default_nettype none

// one-deep register slice, ready passes straight through
module pipeReg #(
    parameter type PayloadT = logic [7:0]
) (
    input  wire logic    btnClk,
    input  wire logic    rst,
    input  wire logic    inValid_i,
    output logic         inReady_o,
    input  wire PayloadT in_i,
    output logic         outValid_o,
    input  wire logic    outReady_i,
    output PayloadT      out_o
);

    logic    full;  // slot holds an item
    PayloadT data;  // held payload

    // take a new item when empty or when the current one leaves
    assign inReady_o = !full || outReady_i;

    always_ff @(posedge btnClk or posedge rst)
    begin
        if (rst)
            full <= 1'b0;
        else if (inReady_o)
            full <= inValid_i;  // refill or drain
    end

    always_ff @(posedge btnClk)
    begin
        if (inValid_i && inReady_o)
            data <= in_i;
    end

    assign outValid_o = full;
    assign out_o      = data;

    // stalled item keeps its valid
    assert property (@(posedge btnClk) disable iff (rst)
        outValid_o && !outReady_i |=> outValid_o);

    // and its payload
    assert property (@(posedge btnClk) disable iff (rst)
        outValid_o && !outReady_i |=> $stable(out_o));

endmodule

`default_nettype wire

//--- hdl/gamePkg.sv
`default_nettype none

package gamePkg;

    ////////////////////////////////////////////////////////////
    // screen and player geometry
    ////////////////////////////////////////////////////////////

    localparam int unsigned ScreenW    = 640;   // visible pixels per line
    localparam int unsigned ScreenH    = 480;   // visible lines
    localparam int unsigned PlayerSize = 12;    // player square side

    typedef logic [9:0] coordT;  // pixel coordinate, 0..1023
    typedef logic [3:0] colorT;  // palette index

    // button nibble, one-hot means a move
    typedef logic [3:0] btnT;

    localparam btnT BtnUp    = 4'h8;
    localparam btnT BtnDown  = 4'h4;
    localparam btnT BtnRight = 4'h2;
    localparam btnT BtnLeft  = 4'h1;

    // set bit blocks that direction
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
    } blockT;

    ////////////////////////////////////////////////////////////
    // static config and stage payloads
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        coordT hStart;   // left edge after reset
        coordT vStart;   // top edge after reset
        coordT width;
        coordT height;
        colorT color;
    } rectCfgT;

    // one game step as it enters the core
    typedef struct packed {
        btnT   rectBtns;
        btnT   playerBtns;
        coordT playerH;     // player left edge
        coordT playerV;     // player top edge
        colorT playerColor;
    } stepReqT;

    typedef struct packed {
        stepReqT req;
        coordT   rectH;     // rectangle left edge after this step
        coordT   rectV;     // rectangle top edge after this step
    } rectStepT;

    typedef struct packed {
        rectStepT step;
        blockT    block;
    } collideStepT;

    // result handed back to the game
    typedef struct packed {
        coordT newH;
        coordT newV;
        blockT block;
        coordT rectH;
        coordT rectV;
    } stepResT;

endpackage

`default_nettype wire
